//--- include/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Slot field widths
`define PIPE_PC_WIDTH    16
`define PIPE_EPOCH_WIDTH 4
`define PIPE_SEQ_WIDTH   8

// Sequential fetch increment
`define PIPE_PC_STEP     4

// Handler entry for exceptions at M and W
`define PIPE_EXCP_VECTOR 16'h0100

`endif

//--- verilog/pipePkg.sv
`default_nettype none

`include "pipe_settings.svh"

package pipePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction slots. valid must stay the first field
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                         valid;
        logic [`PIPE_PC_WIDTH-1:0]    pc;
        logic [`PIPE_EPOCH_WIDTH-1:0] epoch;
    } frontSlot;

    // Same leading fields as frontSlot, issue number appended
    typedef struct packed {
        logic                         valid;
        logic [`PIPE_PC_WIDTH-1:0]    pc;
        logic [`PIPE_EPOCH_WIDTH-1:0] epoch;
        logic [`PIPE_SEQ_WIDTH-1:0]   seq;
    } backSlot;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hazard events and redirect targets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic branchD;
        logic branchM;
        logic iWait;      // I-cache miss
        logic dWait;      // D-cache miss
        logic eWait;      // Multi-cycle execute
        logic overflowI;  // Issue queue full
        logic excpM;
        logic excpW;
    } hazardEvents;

    typedef struct packed {
        logic [`PIPE_PC_WIDTH-1:0] branchTargetD;
        logic [`PIPE_PC_WIDTH-1:0] branchTargetM;
    } redirectReq;

    typedef enum logic [1:0] {
        redirNone    = 2'd0,
        redirBranchD = 2'd1,
        redirBranchM = 2'd2,
        redirExcp    = 2'd3
    } redirectKind;

    // Per-stage stall and flush, plus the fetch redirect request
    typedef struct packed {
        logic        stallF;
        logic        stallF2;
        logic        flushF2;
        logic        stallD;
        logic        flushD;
        logic        stallI;
        logic        flushI;
        logic        stallE;
        logic        flushE;
        logic        stallM;
        logic        flushM;
        logic        stallM2;
        logic        flushM2;
        logic        flushW;
        logic        redirectValid;
        redirectKind redirectSel;
    } hazardCtrl;

endpackage

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  pipePkg::hazardEvents events,
    output pipePkg::hazardCtrl   ctrl
);

    // Redirects hidden behind an I-cache miss
    logic excpPend;
    logic branchMPend;
    logic branchDPend;
    logic excpPendNext;
    logic branchMPendNext;
    logic branchDPendNext;
    logic excpAny;

    assign excpAny = events.excpM | events.excpW;

    always_ff @(posedge clk) begin
        if (reset) begin
            excpPend    <= 1'b0;
            branchMPend <= 1'b0;
            branchDPend <= 1'b0;
        end else begin
            excpPend    <= excpPendNext;
            branchMPend <= branchMPendNext;
            branchDPend <= branchDPendNext;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed priority decision, first match wins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ctrl             = '0;
        ctrl.redirectSel = pipePkg::redirNone;
        excpPendNext     = excpPend;
        branchMPendNext  = branchMPend;
        branchDPendNext  = branchDPend;

        if (excpAny) begin
            ctrl.flushF2       = 1'b1;
            ctrl.flushD        = 1'b1;
            ctrl.flushI        = 1'b1;
            ctrl.flushE        = 1'b1;
            ctrl.flushM        = 1'b1;
            ctrl.redirectValid = 1'b1;
            ctrl.redirectSel   = pipePkg::redirExcp;
            if (events.excpW) begin  // Faulting slot already past M
                ctrl.flushM2 = 1'b1;
                ctrl.flushW  = 1'b1;
            end
            if (events.iWait) begin
                ctrl.stallF  = 1'b1;
                excpPendNext = 1'b1;
            end
        end else if (events.dWait) begin
            ctrl.stallF   = 1'b1;
            ctrl.stallF2  = 1'b1;
            ctrl.stallD   = 1'b1;
            ctrl.stallI   = 1'b1;
            ctrl.stallE   = 1'b1;
            ctrl.stallM   = 1'b1;
            ctrl.flushM2  = 1'b1;  // Bubble below the held load
        end else if (events.branchM) begin
            ctrl.flushF2       = 1'b1;
            ctrl.flushD        = 1'b1;
            ctrl.flushI        = 1'b1;
            ctrl.flushE        = 1'b1;
            ctrl.flushM        = 1'b1;
            ctrl.redirectValid = 1'b1;
            ctrl.redirectSel   = pipePkg::redirBranchM;
            if (events.iWait) begin
                ctrl.stallF     = 1'b1;
                branchMPendNext = 1'b1;
            end
        end else if (events.eWait) begin
            ctrl.stallF  = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD  = 1'b1;
            ctrl.stallI  = 1'b1;
            ctrl.stallE  = 1'b1;
            ctrl.flushM  = 1'b1;
        end else if (events.overflowI) begin
            ctrl.stallF  = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD  = 1'b1;
            ctrl.stallI  = 1'b1;
        end else if (events.branchD) begin
            ctrl.flushF2       = 1'b1;
            ctrl.flushD        = 1'b1;
            ctrl.redirectValid = 1'b1;
            ctrl.redirectSel   = pipePkg::redirBranchD;
            if (events.iWait) begin
                ctrl.stallF     = 1'b1;
                branchDPendNext = 1'b1;
            end
        end else if (events.iWait) begin
            ctrl.stallF  = 1'b1;
            ctrl.flushF2 = 1'b1;
        end

        // Replay the front-end flush once the miss is over
        if (excpPend && !ctrl.stallF) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD  = 1'b1;
            excpPendNext = 1'b0;
        end
        if (branchMPend && !(events.iWait || events.eWait)) begin
            ctrl.flushF2    = 1'b1;
            ctrl.flushD     = 1'b1;
            branchMPendNext = 1'b0;
        end
        if (branchDPend && !events.iWait) begin
            ctrl.flushF2    = 1'b1;
            ctrl.flushD     = 1'b1;
            branchDPendNext = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payloadT = pipePkg::frontSlot
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // valid is the leading field, so it lands on the top bit
    localparam int ValidBit = $bits(payloadT) - 1;

    // Flush over stall over load; only valid is cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            q[ValidBit] <= 1'b0;
        end else if (flush) begin
            q[ValidBit] <= 1'b0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module fetchUnit (
    input  logic                clk,
    input  logic                reset,
    input  pipePkg::hazardCtrl  ctrl,
    input  pipePkg::redirectReq targets,
    output pipePkg::frontSlot   fetchOut
);

    localparam logic [`PIPE_PC_WIDTH-1:0] PcStep = `PIPE_PC_WIDTH'(`PIPE_PC_STEP);

    logic [`PIPE_PC_WIDTH-1:0]    pc;
    logic [`PIPE_PC_WIDTH-1:0]    reqTarget;
    logic [`PIPE_PC_WIDTH-1:0]    pendTarget;
    logic                         pendValid;
    logic [`PIPE_EPOCH_WIDTH-1:0] epoch;

    always_comb begin
        case (ctrl.redirectSel)
            pipePkg::redirBranchD: reqTarget = targets.branchTargetD;
            pipePkg::redirBranchM: reqTarget = targets.branchTargetM;
            pipePkg::redirExcp:    reqTarget = `PIPE_EXCP_VECTOR;
            default:               reqTarget = pc + PcStep;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            epoch     <= '0;
            pendValid <= 1'b0;
        end else if (ctrl.stallF) begin
            if (ctrl.redirectValid) begin  // Park it until fetch is free
                pendTarget <= reqTarget;
                pendValid  <= 1'b1;
            end
        end else if (ctrl.redirectValid) begin  // Newest redirect wins
            pc        <= reqTarget;
            epoch     <= epoch + 1'b1;
            pendValid <= 1'b0;
        end else if (pendValid) begin
            pc        <= pendTarget;
            epoch     <= epoch + 1'b1;
            pendValid <= 1'b0;
        end else begin
            pc <= pc + PcStep;
        end
    end

    assign fetchOut = '{valid: !ctrl.stallF, pc: pc, epoch: epoch};

endmodule

`default_nettype wire

//--- verilog/pipeTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module pipeTop (
    input  logic                 clk,
    input  logic                 reset,
    input  pipePkg::hazardEvents events,
    input  pipePkg::redirectReq  targets,
    output pipePkg::backSlot     retire,
    output pipePkg::hazardCtrl   ctrl
);

    pipePkg::frontSlot fetchOut;
    pipePkg::frontSlot f2Q;
    pipePkg::frontSlot dQ;
    pipePkg::backSlot  iIn;
    pipePkg::backSlot  iQ;
    pipePkg::backSlot  eIn;
    pipePkg::backSlot  eQ;
    pipePkg::backSlot  mQ;
    pipePkg::backSlot  m2Q;

    logic [`PIPE_SEQ_WIDTH-1:0] seqCnt;
    logic                       issueFire;

    hazardUnit u_hazard (
        .clk    (clk),
        .reset  (reset),
        .events (events),
        .ctrl   (ctrl)
    );

    fetchUnit u_fetch (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .targets  (targets),
        .fetchOut (fetchOut)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Front end stages F2 and D
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stageReg #(.payloadT(pipePkg::frontSlot)) u_f2 (
        .clk   (clk),
        .reset (reset),
        .stall (ctrl.stallF2),
        .flush (ctrl.flushF2),
        .d     (fetchOut),
        .q     (f2Q)
    );

    stageReg #(.payloadT(pipePkg::frontSlot)) u_d (
        .clk   (clk),
        .reset (reset),
        .stall (ctrl.stallD),
        .flush (ctrl.flushD),
        .d     (f2Q),
        .q     (dQ)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stamp each slot entering I with the next sequence number
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign issueFire = dQ.valid && !ctrl.stallI && !ctrl.flushI;

    always_ff @(posedge clk) begin
        if (reset) begin
            seqCnt <= '0;
        end else if (issueFire) begin
            seqCnt <= seqCnt + 1'b1;
        end
    end

    assign iIn = '{valid: dQ.valid, pc: dQ.pc, epoch: dQ.epoch, seq: seqCnt};

    stageReg #(.payloadT(pipePkg::backSlot)) u_i (
        .clk   (clk),
        .reset (reset),
        .stall (ctrl.stallI),
        .flush (ctrl.flushI),
        .d     (iIn),
        .q     (iQ)
    );

    // I held on issue overflow while E drains, so E must not copy it
    always_comb begin
        eIn       = iQ;
        eIn.valid = iQ.valid && !ctrl.stallI;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Back end stages E, M, M2 and W
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stageReg #(.payloadT(pipePkg::backSlot)) u_e (
        .clk   (clk),
        .reset (reset),
        .stall (ctrl.stallE),
        .flush (ctrl.flushE),
        .d     (eIn),
        .q     (eQ)
    );

    stageReg #(.payloadT(pipePkg::backSlot)) u_m (
        .clk   (clk),
        .reset (reset),
        .stall (ctrl.stallM),
        .flush (ctrl.flushM),
        .d     (eQ),
        .q     (mQ)
    );

    stageReg #(.payloadT(pipePkg::backSlot)) u_m2 (
        .clk   (clk),
        .reset (reset),
        .stall (ctrl.stallM2),
        .flush (ctrl.flushM2),
        .d     (mQ),
        .q     (m2Q)
    );

    stageReg #(.payloadT(pipePkg::backSlot)) u_w (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),  // W never holds
        .flush (ctrl.flushW),
        .d     (m2Q),
        .q     (retire)
    );

endmodule

`default_nettype wire

//--- dv/pipe_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module hazardChecks (
    input logic                 clk,
    input logic                 reset,
    input pipePkg::hazardEvents events,
    input pipePkg::hazardCtrl   ctrl,
    input logic                 excpPend,
    input logic                 branchMPend,
    input logic                 branchDPend
);

    int   failCount = 0;
    logic replay;

    assign replay = excpPend | branchMPend | branchDPend;

    // Replayed flushes may hit a held F2 or D where flush wins
    stallFlushApart: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.stallI && ctrl.flushI) && !(ctrl.stallE && ctrl.flushE) &&
        !(ctrl.stallM && ctrl.flushM) &&
        (replay || (!(ctrl.stallF2 && ctrl.flushF2) && !(ctrl.stallD && ctrl.flushD))))
        else begin
            failCount++;
            $error("stall and flush active on the same stage");
        end

    excpFlushes: assert property (@(posedge clk) disable iff (reset)
        (events.excpM || events.excpW) |->
            ctrl.flushF2 && ctrl.flushD && ctrl.flushI && ctrl.flushE && ctrl.flushM &&
            (!events.excpW || (ctrl.flushM2 && ctrl.flushW)))
        else begin
            failCount++;
            $error("exception did not flush the pipeline");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pending redirect flags drop once their wait is over
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    excpPendDrops: assert property (@(posedge clk) disable iff (reset)
        excpPend && !ctrl.stallF |=> !excpPend)
        else begin
            failCount++;
            $error("exception pending flag stayed set");
        end

    branchMPendDrops: assert property (@(posedge clk) disable iff (reset)
        branchMPend && !events.iWait && !events.eWait |=> !branchMPend)
        else begin
            failCount++;
            $error("memory branch pending flag stayed set");
        end

    branchDPendDrops: assert property (@(posedge clk) disable iff (reset)
        branchDPend && !events.iWait |=> !branchDPend)
        else begin
            failCount++;
            $error("decode branch pending flag stayed set");
        end

endmodule

bind hazardUnit hazardChecks u_hazardChecks (
    .clk         (clk),
    .reset       (reset),
    .events      (events),
    .ctrl        (ctrl),
    .excpPend    (excpPend),
    .branchMPend (branchMPend),
    .branchDPend (branchDPend)
);

`default_nettype wire

//--- dv/pipeTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_settings.svh"

module pipeTb;

    localparam int ResetCycles = 5;
    localparam int NumTests    = 8;
    localparam int Margin      = 200;

    logic                 clk;
    logic                 reset;
    pipePkg::hazardEvents events;
    pipePkg::redirectReq  targets;
    pipePkg::backSlot     retire;
    pipePkg::hazardCtrl   ctrl;

    string testNames [NumTests] = '{"idle", "branchD", "branchM", "iWaitRedirect",
                                    "backStalls", "exceptions", "mixed", "drain"};
    int    testCycles [NumTests] = '{40, 60, 60, 100, 80, 60, 200, 20};
    // Percent per cycle for branchD branchM iWait dWait eWait overflowI excpM excpW
    int    weights [NumTests][8] = '{'{0, 0, 0, 0, 0, 0, 0, 0},
                                     '{15, 0, 0, 0, 0, 0, 0, 0},
                                     '{0, 15, 0, 0, 0, 0, 0, 0},
                                     '{15, 10, 40, 0, 0, 0, 5, 0},
                                     '{0, 0, 0, 20, 20, 20, 0, 0},
                                     '{0, 0, 10, 0, 0, 0, 8, 8},
                                     '{10, 10, 15, 10, 10, 10, 4, 4},
                                     '{0, 0, 0, 0, 0, 0, 0, 0}};

    string       testName = "reset";
    int          errors   = 0;
    int          checks   = 0;
    int          cycleLimit;
    logic [31:0] rngState;

    // Mirror state of the pipeline
    logic [`PIPE_PC_WIDTH-1:0]    modelPc;
    logic [`PIPE_PC_WIDTH-1:0]    modelPendTarget;
    logic                         modelPendValid;
    logic [`PIPE_EPOCH_WIDTH-1:0] modelEpoch;
    logic [`PIPE_SEQ_WIDTH-1:0]   modelSeq;
    logic                         pendExcp;
    logic                         pendBrM;
    logic                         pendBrD;
    pipePkg::frontSlot            f2Slot;
    pipePkg::frontSlot            dSlot;
    pipePkg::backSlot             iSlot;
    pipePkg::backSlot             eSlot;
    pipePkg::backSlot             mSlot;
    pipePkg::backSlot             m2Slot;
    pipePkg::backSlot             wSlot;

    pipeTop u_dut (
        .clk     (clk),
        .reset   (reset),
        .events  (events),
        .targets (targets),
        .retire  (retire),
        .ctrl    (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int drawPct();
        rngState = lcgNext(rngState);
        return int'(rngState[31:16] % 16'd100);
    endfunction

    function automatic logic [`PIPE_PC_WIDTH-1:0] drawPc();
        rngState = lcgNext(rngState);
        return {rngState[31 -: `PIPE_PC_WIDTH-2], 2'b00};  // Word aligned
    endfunction

    task automatic expectMatch(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s %s expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of the priority list and the replay of hidden redirects
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic pipePkg::hazardCtrl expectedCtrl(input pipePkg::hazardEvents ev,
                                                        input logic pE, input logic pM,
                                                        input logic pD);
        pipePkg::hazardCtrl c;
        c = '0;
        if (ev.excpM || ev.excpW) begin
            {c.flushF2, c.flushD, c.flushI, c.flushE, c.flushM} = 5'b11111;
            c.flushM2       = ev.excpW;
            c.flushW        = ev.excpW;
            c.stallF        = ev.iWait;
            c.redirectValid = 1'b1;
            c.redirectSel   = pipePkg::redirExcp;
        end else if (ev.dWait) begin
            {c.stallF, c.stallF2, c.stallD, c.stallI, c.stallE, c.stallM} = 6'b111111;
            c.flushM2 = 1'b1;
        end else if (ev.branchM) begin
            {c.flushF2, c.flushD, c.flushI, c.flushE, c.flushM} = 5'b11111;
            c.stallF        = ev.iWait;
            c.redirectValid = 1'b1;
            c.redirectSel   = pipePkg::redirBranchM;
        end else if (ev.eWait) begin
            {c.stallF, c.stallF2, c.stallD, c.stallI, c.stallE} = 5'b11111;
            c.flushM = 1'b1;
        end else if (ev.overflowI) begin
            {c.stallF, c.stallF2, c.stallD, c.stallI} = 4'b1111;
        end else if (ev.branchD) begin
            {c.flushF2, c.flushD} = 2'b11;
            c.stallF        = ev.iWait;
            c.redirectValid = 1'b1;
            c.redirectSel   = pipePkg::redirBranchD;
        end else if (ev.iWait) begin
            {c.stallF, c.flushF2} = 2'b11;
        end
        if ((pE && !c.stallF) || (pM && !ev.iWait && !ev.eWait) || (pD && !ev.iWait)) begin
            {c.flushF2, c.flushD} = 2'b11;
        end
        return c;
    endfunction

    // Stages are walked from W upwards so each reads its old upstream slot
    task automatic advanceModel(input pipePkg::hazardCtrl c, input pipePkg::hazardEvents ev,
                                input pipePkg::redirectReq tg);
        logic [`PIPE_PC_WIDTH-1:0] target;
        if (c.flushW) wSlot.valid = 1'b0;
        else wSlot = m2Slot;
        if (c.flushM2) m2Slot.valid = 1'b0;
        else if (!c.stallM2) m2Slot = mSlot;
        if (c.flushM) mSlot.valid = 1'b0;
        else if (!c.stallM) mSlot = eSlot;
        if (c.flushE) begin
            eSlot.valid = 1'b0;
        end else if (!c.stallE) begin
            eSlot       = iSlot;
            eSlot.valid = iSlot.valid && !c.stallI;  // Held I leaves a bubble in E
        end
        if (c.flushI) iSlot.valid = 1'b0;
        else if (!c.stallI) iSlot = '{valid: dSlot.valid, pc: dSlot.pc, epoch: dSlot.epoch,
                                      seq: modelSeq};
        if (dSlot.valid && !c.stallI && !c.flushI) modelSeq = modelSeq + 1'b1;
        if (c.flushD) dSlot.valid = 1'b0;
        else if (!c.stallD) dSlot = f2Slot;
        if (c.flushF2) f2Slot.valid = 1'b0;
        else if (!c.stallF2) f2Slot = '{valid: !c.stallF, pc: modelPc, epoch: modelEpoch};

        if (c.redirectSel == pipePkg::redirExcp) target = `PIPE_EXCP_VECTOR;
        else if (c.redirectSel == pipePkg::redirBranchM) target = tg.branchTargetM;
        else target = tg.branchTargetD;
        if (c.stallF) begin
            if (c.redirectValid) begin
                modelPendTarget = target;
                modelPendValid  = 1'b1;
            end
        end else if (c.redirectValid || modelPendValid) begin
            modelPc        = c.redirectValid ? target : modelPendTarget;
            modelEpoch     = modelEpoch + 1'b1;
            modelPendValid = 1'b0;
        end else begin
            modelPc = modelPc + `PIPE_PC_WIDTH'(`PIPE_PC_STEP);
        end

        if (pendExcp && !c.stallF) pendExcp = 1'b0;
        if (pendBrM && !ev.iWait && !ev.eWait) pendBrM = 1'b0;
        if (pendBrD && !ev.iWait) pendBrD = 1'b0;
        if (c.redirectValid && c.stallF) begin  // Redirect hidden by the miss
            if (c.redirectSel == pipePkg::redirExcp) pendExcp = 1'b1;
            else if (c.redirectSel == pipePkg::redirBranchM) pendBrM = 1'b1;
            else pendBrD = 1'b1;
        end
    endtask

    initial begin : scoreboard
        pipePkg::hazardCtrl want;
        modelPc         = '0;
        modelPendTarget = '0;
        modelPendValid  = 1'b0;
        modelEpoch      = '0;
        modelSeq        = '0;
        {pendExcp, pendBrM, pendBrD} = 3'b000;
        {f2Slot, dSlot, iSlot, eSlot, mSlot, m2Slot, wSlot} = '0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                want = expectedCtrl(events, pendExcp, pendBrM, pendBrD);
                expectMatch("ctrl", 64'(want), 64'(ctrl));
                expectMatch("retire.valid", 64'(wSlot.valid), 64'(retire.valid));
                if (wSlot.valid) expectMatch("retire", 64'(wSlot), 64'(retire));
                advanceModel(want, events, targets);
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles without a verdict", cycleLimit);
        $display("Simulation failed");
        $finish;
    end

    task automatic runTest(input int t);
        logic [7:0] draw;
        testName = testNames[t];
        repeat (testCycles[t]) begin
            @(negedge clk);
            for (int j = 0; j < 8; j++) begin
                draw[7 - j] = drawPct() < weights[t][j];
            end
            events                = pipePkg::hazardEvents'(draw);
            targets.branchTargetD = drawPc();
            targets.branchTargetM = drawPc();
        end
    endtask

    initial begin : stimulus
        int total;
        rngState   = 32'h880b;
        reset      = 1'b1;
        events     = '0;
        targets    = '0;
        total      = 0;
        foreach (testCycles[t]) total += testCycles[t];
        cycleLimit = total + ResetCycles + Margin;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < NumTests; t++) runTest(t);
        @(negedge clk);
        $display("Done: %0d checks, %0d mismatches, %0d assertion failures", checks, errors,
                 u_dut.u_hazard.u_hazardChecks.failCount);
        if (errors == 0 && u_dut.u_hazard.u_hazardChecks.failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
verilog/pipePkg.sv
verilog/hazardUnit.sv
verilog/stageReg.sv
verilog/fetchUnit.sv
verilog/pipeTop.sv
dv/pipe_assertions.sv
dv/pipeTb.sv

//--- Makefile
SIM      := verilator
TOP      := pipeTb
FILELIST := vlog.f
FLAGS    := --binary --timing --assert -j 0
OBJDIR   := obj_dir
LOG      := sim.log
RUNFLAGS := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
